/* design/chip8_isa_pkg.sv */
package chip8_isa_pkg;

    // One data register value
    typedef logic [7:0] vreg_t;

    // Register index V0..VF
    typedef logic [3:0] vidx_t;

    // Number of data registers
    localparam int NUM_VREGS = 16;

    // Index of VF, the flag register
    localparam vidx_t FLAG_REG = 4'hF;

    // Programs start here after reset
    localparam logic [11:0] RESET_PC = 12'h200;

    // Instruction word, kk and nnn come from part selects
    typedef struct packed {
        logic [3:0] op;
        vidx_t      x;
        vidx_t      y;
        logic [3:0] n;
    } instr_t;

    // Opcode classes by top nibble
    localparam logic [3:0] OP_SYS    = 4'h0;
    localparam logic [3:0] OP_JP     = 4'h1;
    localparam logic [3:0] OP_CALL   = 4'h2;
    localparam logic [3:0] OP_SE_KK  = 4'h3;
    localparam logic [3:0] OP_SNE_KK = 4'h4;
    localparam logic [3:0] OP_SE_XY  = 4'h5;
    localparam logic [3:0] OP_LD_KK  = 4'h6;
    localparam logic [3:0] OP_ADD_KK = 4'h7;
    localparam logic [3:0] OP_ALU    = 4'h8;
    localparam logic [3:0] OP_SNE_XY = 4'h9;
    localparam logic [3:0] OP_LD_I   = 4'hA;
    localparam logic [3:0] OP_JP_V0  = 4'hB;
    localparam logic [3:0] OP_MISC   = 4'hF;

    // Fx sub-codes in the low byte
    localparam logic [7:0] MISC_ADD_I = 8'h1E;
    localparam logic [7:0] MISC_BCD   = 8'h33;
    localparam logic [7:0] MISC_STORE = 8'h55;
    localparam logic [7:0] MISC_LOAD  = 8'h65;

    // ALU operations
    typedef enum logic [3:0] {
        ALU_PASS_KK,
        ALU_ADD_KK,
        ALU_PASS_Y,
        ALU_OR,
        ALU_AND,
        ALU_XOR,
        ALU_ADD,
        ALU_SUB,
        ALU_SHR,
        ALU_SUBN,
        ALU_SHL
    } alu_op_t;

    // Result byte plus the bit bound for VF
    typedef struct packed {
        vreg_t result;
        logic  carry;
    } alu_res_t;

    // Decimal digits of one byte
    typedef struct packed {
        logic [3:0] hundreds;
        logic [3:0] tens;
        logic [3:0] ones;
    } bcd_t;

endpackage

/* design/chip8_mem_pkg.sv */
package chip8_mem_pkg;

    // 4 KiB address space
    localparam int ADDR_W = 12;

    typedef logic [ADDR_W-1:0] addr_t;

    // Read is a held level, write is a single-cycle pulse
    typedef struct packed {
        logic       read;
        logic       write;
        addr_t      addr;
        logic [7:0] wdata;
    } mem_req_t;

    // Ack qualifies rdata for a held read
    typedef struct packed {
        logic       ack;
        logic [7:0] rdata;
    } mem_rsp_t;

endpackage

/* design/chip8_regfile.sv */
module chip8_regfile (
    input  logic                  clk,
    input  logic                  reset_i,
    // Data register write port
    input  logic                  wr_en_i,
    input  chip8_isa_pkg::vidx_t  wr_idx_i,
    input  chip8_isa_pkg::vreg_t  wr_data_i,
    // I register load
    input  logic                  i_load_i,
    input  logic [15:0]           i_data_i,
    // Two combinational read ports
    input  chip8_isa_pkg::vidx_t  rd_x_idx_i,
    input  chip8_isa_pkg::vidx_t  rd_y_idx_i,
    output chip8_isa_pkg::vreg_t  rd_x_o,
    output chip8_isa_pkg::vreg_t  rd_y_o,
    output logic [15:0]           i_o
);
    import chip8_isa_pkg::*;

    // V0..VF
    vreg_t       v_q [NUM_VREGS];
    // Index register, only the low bits reach memory
    logic [15:0] i_q;

    always_ff @(posedge clk) begin
        if (reset_i) begin
            for (int k = 0; k < NUM_VREGS; k++) begin
                v_q[k] <= '0;
            end
            i_q <= '0;
        end else begin
            if (wr_en_i) begin
                v_q[wr_idx_i] <= wr_data_i;
            end
            if (i_load_i) begin
                i_q <= i_data_i;
            end
        end
    end

    // Reads see the value before this cycle's write
    assign rd_x_o = v_q[rd_x_idx_i];
    assign rd_y_o = v_q[rd_y_idx_i];
    assign i_o    = i_q;

endmodule

/* design/chip8_alu.sv */
module chip8_alu (
    input  chip8_isa_pkg::alu_op_t  op_i,
    input  chip8_isa_pkg::vreg_t    a_i,
    input  chip8_isa_pkg::vreg_t    b_i,
    input  chip8_isa_pkg::vreg_t    kk_i,
    output chip8_isa_pkg::alu_res_t res_o,
    output logic                    equal_o,
    output chip8_isa_pkg::bcd_t     bcd_o
);
    import chip8_isa_pkg::*;

    // Nine-bit sums keep the carry out
    logic [8:0]  sum_xy;
    logic [8:0]  sum_kk;
    // Double-dabble shift register, digits above the binary byte
    logic [19:0] dd;

    assign sum_xy = {1'b0, a_i} + {1'b0, b_i};
    assign sum_kk = {1'b0, a_i} + {1'b0, kk_i};

    always_comb begin
        res_o.result = kk_i;
        res_o.carry  = 1'b0;
        case (op_i)
            ALU_PASS_KK: res_o.result = kk_i;
            // Wraps, VF untouched
            ALU_ADD_KK:  res_o.result = sum_kk[7:0];
            ALU_PASS_Y:  res_o.result = b_i;
            ALU_OR:      res_o.result = a_i | b_i;
            ALU_AND:     res_o.result = a_i & b_i;
            ALU_XOR:     res_o.result = a_i ^ b_i;
            ALU_ADD: begin
                res_o.result = sum_xy[7:0];
                res_o.carry  = sum_xy[8];
            end
            // Carry is NOT borrow, strict compare
            ALU_SUB: begin
                res_o.result = a_i - b_i;
                res_o.carry  = a_i > b_i;
            end
            ALU_SUBN: begin
                res_o.result = b_i - a_i;
                res_o.carry  = b_i > a_i;
            end
            // Shifts work on Vx
            ALU_SHR: begin
                res_o.result = a_i >> 1;
                res_o.carry  = a_i[0];
            end
            ALU_SHL: begin
                res_o.result = a_i << 1;
                res_o.carry  = a_i[7];
            end
            default: res_o.result = kk_i;
        endcase
    end

    // Immediate compare for the kk forms, register compare otherwise
    assign equal_o = (op_i == ALU_PASS_KK || op_i == ALU_ADD_KK) ? (a_i == kk_i)
                                                                 : (a_i == b_i);

    always_comb begin
        dd = {12'h000, a_i};
        for (int k = 0; k < 8; k++) begin
            // Add 3 to any digit of 5 or more before the shift
            if (dd[11:8] >= 4'd5) begin
                dd[11:8] = dd[11:8] + 4'd3;
            end
            if (dd[15:12] >= 4'd5) begin
                dd[15:12] = dd[15:12] + 4'd3;
            end
            dd = dd << 1;
        end
    end

    assign bcd_o.hundreds = dd[19:16];
    assign bcd_o.tens     = dd[15:12];
    assign bcd_o.ones     = dd[11:8];

endmodule

/* design/chip8_stack.sv */
module chip8_stack #(
    parameter int STACK_DEPTH = 16
) (
    input  logic                 clk,
    input  logic                 reset_i,
    input  logic                 push_i,
    input  logic                 pop_i,
    input  chip8_mem_pkg::addr_t push_addr_i,
    output chip8_mem_pkg::addr_t top_o
);
    import chip8_mem_pkg::*;

    localparam int SP_W = (STACK_DEPTH > 1) ? $clog2(STACK_DEPTH) : 1;
    localparam logic [SP_W-1:0] SP_LAST = SP_W'(STACK_DEPTH - 1);

    // Return addresses
    addr_t           mem_q [STACK_DEPTH];
    // Points at the next free entry
    logic [SP_W-1:0] sp_q;
    logic [SP_W-1:0] sp_dec;

    // Explicit wrap so depths that are not a power of two work too
    assign sp_dec = (sp_q == '0) ? SP_LAST : sp_q - 1'b1;

    always_ff @(posedge clk) begin
        if (reset_i) begin
            sp_q <= '0;
        end else if (push_i) begin
            sp_q <= (sp_q == SP_LAST) ? '0 : sp_q + 1'b1;
        end else if (pop_i) begin
            sp_q <= sp_dec;
        end
    end

    always_ff @(posedge clk) begin
        if (push_i) begin
            mem_q[sp_q] <= push_addr_i;
        end
    end

    // Entry just below the pointer
    assign top_o = mem_q[sp_dec];

endmodule

/* design/chip8_control.sv */
module chip8_control (
    input  logic                     clk,
    input  logic                     reset_i,
    input  logic                     cpu_tick_i,
    // Memory port
    output chip8_mem_pkg::mem_req_t  mem_req_o,
    input  chip8_mem_pkg::mem_rsp_t  mem_rsp_i,
    output logic                     idle_o,
    // Register file
    output logic                     rf_wr_en_o,
    output chip8_isa_pkg::vidx_t     rf_wr_idx_o,
    output chip8_isa_pkg::vreg_t     rf_wr_data_o,
    output logic                     rf_i_load_o,
    output logic [15:0]              rf_i_data_o,
    output chip8_isa_pkg::vidx_t     rf_rd_x_idx_o,
    output chip8_isa_pkg::vidx_t     rf_rd_y_idx_o,
    input  chip8_isa_pkg::vreg_t     rf_rd_x_i,
    input  chip8_isa_pkg::vreg_t     rf_rd_y_i,
    input  logic [15:0]              rf_i_i,
    // ALU
    output chip8_isa_pkg::alu_op_t   alu_op_o,
    output chip8_isa_pkg::vreg_t     alu_a_o,
    output chip8_isa_pkg::vreg_t     alu_b_o,
    output chip8_isa_pkg::vreg_t     alu_kk_o,
    input  chip8_isa_pkg::alu_res_t  alu_res_i,
    input  logic                     alu_equal_i,
    input  chip8_isa_pkg::bcd_t      alu_bcd_i,
    // Return stack
    output logic                     stk_push_o,
    output logic                     stk_pop_o,
    output chip8_mem_pkg::addr_t     stk_push_addr_o,
    input  chip8_mem_pkg::addr_t     stk_top_i
);
    import chip8_isa_pkg::*;
    import chip8_mem_pkg::*;

    typedef enum logic [3:0] {
        ST_FETCH_HI, ST_FETCH_LO, ST_DECODE,
        ST_WR_FLAG, ST_WR_VX,
        ST_BCD0, ST_BCD1, ST_BCD2,
        ST_STORE, ST_LOAD, ST_IDLE
    } state_t;

    state_t state;
    addr_t  pc;
    // Transfer counter for Fx55 and Fx65
    vidx_t  cnt;
    // Held read request
    logic   rd_q;
    addr_t  rd_addr_q;
    instr_t ir;
    // Writeback value latched in decode, VF may change before Vx lands
    vreg_t  result_q;
    logic   carry_q;
    logic   rd_done;
    addr_t  i_addr;
    logic   alu_known;
    logic   flag_wr;

    assign rd_done = rd_q && mem_rsp_i.ack;
    assign i_addr  = rf_i_i[ADDR_W-1:0];
    assign idle_o  = (state == ST_IDLE);

    // ALU op from the opcode class, skips use the pass ops for their compare
    always_comb begin
        alu_op_o  = ALU_PASS_KK;
        alu_known = 1'b1;
        flag_wr   = 1'b0;
        case (ir.op)
            OP_SE_XY, OP_SNE_XY: alu_op_o = ALU_PASS_Y;
            OP_ADD_KK:           alu_op_o = ALU_ADD_KK;
            OP_ALU: begin
                flag_wr = ir.n inside {4'h4, 4'h5, 4'h6, 4'h7, 4'hE};
                case (ir.n)
                    4'h0:    alu_op_o = ALU_PASS_Y;
                    4'h1:    alu_op_o = ALU_OR;
                    4'h2:    alu_op_o = ALU_AND;
                    4'h3:    alu_op_o = ALU_XOR;
                    4'h4:    alu_op_o = ALU_ADD;
                    4'h5:    alu_op_o = ALU_SUB;
                    4'h6:    alu_op_o = ALU_SHR;
                    4'h7:    alu_op_o = ALU_SUBN;
                    4'hE:    alu_op_o = ALU_SHL;
                    default: alu_known = 1'b0;
                endcase
            end
            default: alu_op_o = ALU_PASS_KK;
        endcase
    end

    assign alu_a_o  = rf_rd_x_i;
    assign alu_b_o  = rf_rd_y_i;
    assign alu_kk_o = ir[7:0];

    // Bnnn reads V0, the store loop walks the counter
    assign rf_rd_x_idx_o = (state == ST_STORE) ? cnt :
                           (state == ST_DECODE && ir.op == OP_JP_V0) ? 4'h0 : ir.x;
    assign rf_rd_y_idx_o = ir.y;

    // Single register write port
    always_comb begin
        rf_wr_en_o   = 1'b0;
        rf_wr_idx_o  = ir.x;
        rf_wr_data_o = result_q;
        case (state)
            ST_WR_FLAG: begin
                rf_wr_en_o   = 1'b1;
                rf_wr_idx_o  = FLAG_REG;
                rf_wr_data_o = {7'h00, carry_q};
            end
            ST_WR_VX: rf_wr_en_o = 1'b1;
            ST_LOAD: begin
                rf_wr_en_o   = rd_done;
                rf_wr_idx_o  = cnt;
                rf_wr_data_o = mem_rsp_i.rdata;
            end
            default: rf_wr_en_o = 1'b0;
        endcase
    end

    // I loads from Annn and Fx1E, and I+x+1 after the last transfer
    always_comb begin
        rf_i_load_o = 1'b0;
        rf_i_data_o = rf_i_i + {12'h000, ir.x} + 16'd1;
        if (state == ST_DECODE && ir.op == OP_LD_I) begin
            rf_i_load_o = 1'b1;
            rf_i_data_o = {4'h0, ir[11:0]};
        end else if (state == ST_DECODE && ir.op == OP_MISC && ir[7:0] == MISC_ADD_I) begin
            rf_i_load_o = 1'b1;
            rf_i_data_o = rf_i_i + {8'h00, rf_rd_x_i};
        end else if (state == ST_STORE && cnt == ir.x) begin
            rf_i_load_o = 1'b1;
        end else if (state == ST_LOAD && rd_done && cnt == ir.x) begin
            rf_i_load_o = 1'b1;
        end
    end

    assign stk_push_o      = (state == ST_DECODE) && (ir.op == OP_CALL);
    assign stk_pop_o       = (state == ST_DECODE) && (ir.op == OP_SYS) && (ir[11:0] == 12'h0EE);
    assign stk_push_addr_o = pc + 12'd2;

    // Writes come straight from the state, reads from the held request
    always_comb begin
        mem_req_o.read  = rd_q;
        mem_req_o.write = 1'b0;
        mem_req_o.addr  = rd_addr_q;
        mem_req_o.wdata = rf_rd_x_i;
        case (state)
            ST_BCD0: begin
                mem_req_o.write = 1'b1;
                mem_req_o.addr  = i_addr;
                mem_req_o.wdata = {4'h0, alu_bcd_i.hundreds};
            end
            ST_BCD1: begin
                mem_req_o.write = 1'b1;
                mem_req_o.addr  = i_addr + 12'd1;
                mem_req_o.wdata = {4'h0, alu_bcd_i.tens};
            end
            ST_BCD2: begin
                mem_req_o.write = 1'b1;
                mem_req_o.addr  = i_addr + 12'd2;
                mem_req_o.wdata = {4'h0, alu_bcd_i.ones};
            end
            ST_STORE: begin
                mem_req_o.write = 1'b1;
                mem_req_o.addr  = i_addr + addr_t'(cnt);
            end
            default: mem_req_o.write = 1'b0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            state <= ST_FETCH_HI;
            pc    <= RESET_PC;
            cnt   <= '0;
            rd_q  <= 1'b0;
        end else begin
            case (state)
                // Each byte is one handshake, read drops after ack
                ST_FETCH_HI: begin
                    rd_q  <= !rd_done;
                    state <= rd_done ? ST_FETCH_LO : ST_FETCH_HI;
                end
                ST_FETCH_LO: begin
                    rd_q  <= !rd_done;
                    state <= rd_done ? ST_DECODE : ST_FETCH_LO;
                end
                ST_DECODE: begin
                    state <= ST_IDLE;
                    pc    <= pc + 12'd2;
                    case (ir.op)
                        OP_SYS: begin
                            if (stk_pop_o) begin
                                pc <= stk_top_i;
                            end
                        end
                        OP_JP, OP_CALL: pc <= ir[11:0];
                        OP_JP_V0:       pc <= ir[11:0] + {4'h0, rf_rd_x_i};
                        // Taken skips step over the next instruction
                        OP_SE_KK: begin
                            if (alu_equal_i) begin
                                pc <= pc + 12'd4;
                            end
                        end
                        OP_SNE_KK: begin
                            if (!alu_equal_i) begin
                                pc <= pc + 12'd4;
                            end
                        end
                        OP_SE_XY: begin
                            if (ir.n == 4'h0 && alu_equal_i) begin
                                pc <= pc + 12'd4;
                            end
                        end
                        OP_SNE_XY: begin
                            if (ir.n == 4'h0 && !alu_equal_i) begin
                                pc <= pc + 12'd4;
                            end
                        end
                        OP_LD_KK, OP_ADD_KK: state <= ST_WR_VX;
                        OP_ALU: begin
                            if (alu_known) begin
                                state <= flag_wr ? ST_WR_FLAG : ST_WR_VX;
                            end
                        end
                        OP_MISC: begin
                            cnt <= '0;
                            case (ir[7:0])
                                MISC_BCD:   state <= ST_BCD0;
                                MISC_STORE: state <= ST_STORE;
                                MISC_LOAD:  state <= ST_LOAD;
                                default:    state <= ST_IDLE;
                            endcase
                        end
                        default: state <= ST_IDLE;
                    endcase
                end
                // VF lands before Vx so Vx wins when x is F
                ST_WR_FLAG: state <= ST_WR_VX;
                ST_WR_VX:   state <= ST_IDLE;
                ST_BCD0:    state <= ST_BCD1;
                ST_BCD1:    state <= ST_BCD2;
                ST_BCD2:    state <= ST_IDLE;
                ST_STORE: begin
                    cnt <= cnt + 1'b1;
                    if (cnt == ir.x) begin
                        state <= ST_IDLE;
                    end
                end
                ST_LOAD: begin
                    rd_q <= !rd_done;
                    if (rd_done) begin
                        cnt <= cnt + 1'b1;
                        if (cnt == ir.x) begin
                            state <= ST_IDLE;
                        end
                    end
                end
                // Wait for the tick, then start the next fetch at once
                ST_IDLE: begin
                    if (cpu_tick_i) begin
                        rd_q  <= 1'b1;
                        state <= ST_FETCH_HI;
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    // Payload registers
    always_ff @(posedge clk) begin
        case (state)
            ST_FETCH_HI, ST_IDLE: rd_addr_q <= pc;
            ST_FETCH_LO:          rd_addr_q <= pc + 12'd1;
            ST_LOAD:              rd_addr_q <= i_addr + addr_t'(cnt);
            default:              rd_addr_q <= rd_addr_q;
        endcase
        if (state == ST_FETCH_HI && rd_done) begin
            ir[15:8] <= mem_rsp_i.rdata;
        end
        if (state == ST_FETCH_LO && rd_done) begin
            ir[7:0] <= mem_rsp_i.rdata;
        end
        if (state == ST_DECODE) begin
            result_q <= alu_res_i.result;
            carry_q  <= alu_res_i.carry;
        end
    end

endmodule

/* design/chip8_cpu.sv */
module chip8_cpu #(
    parameter int STACK_DEPTH = 16
) (
    input  logic                    clk,
    input  logic                    reset_i,
    input  logic                    cpu_tick_i,
    output chip8_mem_pkg::mem_req_t mem_req_o,
    input  chip8_mem_pkg::mem_rsp_t mem_rsp_i,
    output logic                    idle_o
);
    import chip8_isa_pkg::*;
    import chip8_mem_pkg::*;

    // Register file
    logic        rf_wr_en;
    vidx_t       rf_wr_idx;
    vreg_t       rf_wr_data;
    logic        rf_i_load;
    logic [15:0] rf_i_data;
    vidx_t       rf_rd_x_idx;
    vidx_t       rf_rd_y_idx;
    vreg_t       rf_rd_x;
    vreg_t       rf_rd_y;
    logic [15:0] rf_i;

    // ALU
    alu_op_t     alu_op;
    vreg_t       alu_a;
    vreg_t       alu_b;
    vreg_t       alu_kk;
    alu_res_t    alu_res;
    logic        alu_equal;
    bcd_t        alu_bcd;

    // Return stack
    logic        stk_push;
    logic        stk_pop;
    addr_t       stk_push_addr;
    addr_t       stk_top;

    chip8_control u_control (
        .clk             (clk),
        .reset_i         (reset_i),
        .cpu_tick_i      (cpu_tick_i),
        .mem_req_o       (mem_req_o),
        .mem_rsp_i       (mem_rsp_i),
        .idle_o          (idle_o),
        .rf_wr_en_o      (rf_wr_en),
        .rf_wr_idx_o     (rf_wr_idx),
        .rf_wr_data_o    (rf_wr_data),
        .rf_i_load_o     (rf_i_load),
        .rf_i_data_o     (rf_i_data),
        .rf_rd_x_idx_o   (rf_rd_x_idx),
        .rf_rd_y_idx_o   (rf_rd_y_idx),
        .rf_rd_x_i       (rf_rd_x),
        .rf_rd_y_i       (rf_rd_y),
        .rf_i_i          (rf_i),
        .alu_op_o        (alu_op),
        .alu_a_o         (alu_a),
        .alu_b_o         (alu_b),
        .alu_kk_o        (alu_kk),
        .alu_res_i       (alu_res),
        .alu_equal_i     (alu_equal),
        .alu_bcd_i       (alu_bcd),
        .stk_push_o      (stk_push),
        .stk_pop_o       (stk_pop),
        .stk_push_addr_o (stk_push_addr),
        .stk_top_i       (stk_top)
    );

    chip8_regfile u_regfile (
        .clk        (clk),
        .reset_i    (reset_i),
        .wr_en_i    (rf_wr_en),
        .wr_idx_i   (rf_wr_idx),
        .wr_data_i  (rf_wr_data),
        .i_load_i   (rf_i_load),
        .i_data_i   (rf_i_data),
        .rd_x_idx_i (rf_rd_x_idx),
        .rd_y_idx_i (rf_rd_y_idx),
        .rd_x_o     (rf_rd_x),
        .rd_y_o     (rf_rd_y),
        .i_o        (rf_i)
    );

    chip8_alu u_alu (
        .op_i    (alu_op),
        .a_i     (alu_a),
        .b_i     (alu_b),
        .kk_i    (alu_kk),
        .res_o   (alu_res),
        .equal_o (alu_equal),
        .bcd_o   (alu_bcd)
    );

    chip8_stack #(
        .STACK_DEPTH (STACK_DEPTH)
    ) u_stack (
        .clk         (clk),
        .reset_i     (reset_i),
        .push_i      (stk_push),
        .pop_i       (stk_pop),
        .push_addr_i (stk_push_addr),
        .top_o       (stk_top)
    );

endmodule

/* sim/chip8_properties.sv */
module chip8_properties (
    input logic                    clk,
    input logic                    reset_i,
    input chip8_mem_pkg::mem_req_t mem_req_o,
    input chip8_mem_pkg::mem_rsp_t mem_rsp_i,
    input logic                    idle_o
);
    timeunit 1ns;
    timeprecision 100ps;

    // Port carries one direction at a time
    no_read_write: assert property (@(posedge clk) disable iff (reset_i)
        !(mem_req_o.read && mem_req_o.write))
        else $error("read and write high together");

    // Pending read keeps its level and address until ack
    read_held: assert property (@(posedge clk) disable iff (reset_i)
        (mem_req_o.read && !mem_rsp_i.ack) |=> (mem_req_o.read && $stable(mem_req_o.addr)))
        else $error("read dropped or moved before ack");

    // Idle only between instructions
    idle_quiet: assert property (@(posedge clk) disable iff (reset_i)
        (mem_req_o.read || mem_req_o.write) |-> !idle_o)
        else $error("idle high during a memory access");

    // First cycle out of reset is quiet
    reset_quiet: assert property (@(posedge clk)
        $fell(reset_i) |-> (!mem_req_o.read && !mem_req_o.write))
        else $error("request high right after reset");

endmodule

bind chip8_cpu chip8_properties props0 (
    .clk       (clk),
    .reset_i   (reset_i),
    .mem_req_o (mem_req_o),
    .mem_rsp_i (mem_rsp_i),
    .idle_o    (idle_o)
);

/* sim/chip8_tb.sv */
module chip8_tb;
    timeunit 1ns;
    timeprecision 100ps;

    import chip8_isa_pkg::*;
    import chip8_mem_pkg::*;

    // All five programs together run well under a thousand cycles
    localparam int TIMEOUT_CYCLES = 4000;

    logic     clk;
    logic     reset_i;
    logic     cpu_tick_i;
    mem_req_t mem_req;
    mem_rsp_t mem_rsp;
    logic     idle;

    logic [7:0] mem [4096];
    // Every read request address and every write address, in order
    addr_t      read_log [$];
    addr_t      write_log [$];
    int         cycle_cnt;
    // Next free program slot and the instruction count of the program
    addr_t      fill_addr;
    int         n_instr;
    // Reference register file
    vreg_t      v_ref [16];

    chip8_cpu #(
        .STACK_DEPTH (16)
    ) dut0 (
        .clk        (clk),
        .reset_i    (reset_i),
        .cpu_tick_i (cpu_tick_i),
        .mem_req_o  (mem_req),
        .mem_rsp_i  (mem_rsp),
        .idle_o     (idle)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    initial begin
        mem_rsp <= '0;
    end

    // Memory answers a held read one cycle later, writes land at once
    always @(posedge clk) begin
        if (reset_i) begin
            mem_rsp.ack <= 1'b0;
        end else if (mem_req.read && !mem_rsp.ack) begin
            mem_rsp.ack   <= 1'b1;
            mem_rsp.rdata <= mem[mem_req.addr];
            read_log.push_back(mem_req.addr);
        end else begin
            mem_rsp.ack <= 1'b0;
        end
        if (mem_req.write) begin
            mem[mem_req.addr] = mem_req.wdata;
            write_log.push_back(mem_req.addr);
        end
    end

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt == TIMEOUT_CYCLES) begin
            $display("timeout: the CPU did not finish its programs in %0d cycles", cycle_cnt);
            $display("Done: errors found");
            $fatal(1, "run stopped by the cycle limit");
        end
    end

    task automatic fail_value(input string name, input logic [15:0] exp, input logic [15:0] act);
        $display("mismatch %s expected %h actual %h", name, exp, act);
        $display("Done: errors found");
        $fatal(1, "stopping at the first error");
    endtask

    task automatic compare_byte(input string name, input vreg_t exp, input vreg_t act);
        if (exp !== act) begin
            fail_value(name, {8'h00, exp}, {8'h00, act});
        end
    endtask

    task automatic compare_addr(input string name, input addr_t exp, input addr_t act);
        if (exp !== act) begin
            fail_value(name, {4'h0, exp}, {4'h0, act});
        end
    endtask

    task automatic compare_bcd(input string name, input bcd_t exp, input bcd_t act);
        if (exp !== act) begin
            fail_value(name, {4'h0, exp}, {4'h0, act});
        end
    endtask

    // Fill depends on all twelve address bits
    task automatic clear_memory();
        for (int a = 0; a < 4096; a++) begin
            mem[a] = 8'(a) ^ {4'(a >> 8), 4'(a >> 8)};
        end
        fill_addr = RESET_PC;
        n_instr   = 0;
    endtask

    task automatic place(input addr_t addr, input logic [15:0] word);
        mem[addr]         = word[15:8];
        mem[addr + 12'd1] = word[7:0];
    endtask

    task automatic emit(input logic [15:0] word);
        place(fill_addr, word);
        fill_addr = fill_addr + 12'd2;
        n_instr++;
    endtask

    // Reset, then tick the CPU each time it goes idle, for n instructions
    task automatic run_program(input int n);
        int done;
        done = 0;
        @(posedge clk);
        reset_i    <= 1'b1;
        cpu_tick_i <= 1'b0;
        repeat (3) @(posedge clk);
        reset_i <= 1'b0;
        read_log.delete();
        write_log.delete();
        while (done < n) begin
            @(negedge clk);
            if (idle) begin
                done++;
                if (done < n) begin
                    @(posedge clk);
                    cpu_tick_i <= 1'b1;
                    @(posedge clk);
                    cpu_tick_i <= 1'b0;
                end
            end
        end
    endtask

    // 8xyn on the reference registers, VF first and Vx after it
    task automatic exec_alu(input logic [3:0] n, input vidx_t x, input vidx_t y);
        int    a;
        int    b;
        int    r;
        logic  carry;
        logic  flag;
        a     = int'(v_ref[x]);
        b     = int'(v_ref[y]);
        carry = 1'b0;
        flag  = 1'b1;
        case (n)
            4'h0:    r = b;
            4'h1:    r = a | b;
            4'h2:    r = a & b;
            4'h3:    r = a ^ b;
            4'h4:    r = a + b;
            4'h5:    r = a - b + 256;
            4'h6:    r = a / 2;
            4'h7:    r = b - a + 256;
            default: r = a * 2;
        endcase
        // Logical ops leave VF alone
        case (n)
            4'h4:    carry = r > 255;
            4'h5:    carry = a > b;
            4'h6:    carry = a[0];
            4'h7:    carry = b > a;
            4'hE:    carry = a >= 128;
            default: flag = 1'b0;
        endcase
        emit({4'h8, x, y, n});
        if (flag) begin
            v_ref[15] = {7'h00, carry};
        end
        v_ref[x] = 8'(r % 256);
    endtask

    task automatic test_alu();
        vreg_t kk;
        clear_memory();
        for (int x = 0; x < 16; x++) begin
            v_ref[x] = 8'h00;
        end
        for (int x = 0; x < 15; x++) begin
            v_ref[x] = 8'($urandom);
            emit({4'h6, 4'(x), v_ref[x]});
        end
        kk = 8'($urandom);
        emit({8'h70, kk});
        v_ref[0] = v_ref[0] + kk;
        exec_alu(4'h0, 4'h1, 4'h2);
        exec_alu(4'h1, 4'h3, 4'h4);
        exec_alu(4'h2, 4'h5, 4'h6);
        exec_alu(4'h3, 4'h7, 4'h8);
        exec_alu(4'h4, 4'h9, 4'hA);
        exec_alu(4'h5, 4'hB, 4'hC);
        exec_alu(4'h6, 4'hD, 4'h0);
        exec_alu(4'h7, 4'hE, 4'h1);
        exec_alu(4'hE, 4'h2, 4'h3);
        // Flag register as destination, the sum must win over the carry
        exec_alu(4'h4, 4'hF, 4'h3);
        emit(16'hA300);
        emit(16'hFF55);
        run_program(n_instr);
        for (int k = 0; k < 16; k++) begin
            compare_byte($sformatf("alu V%0h", k), v_ref[k], mem[12'h300 + 12'(k)]);
        end
    endtask

    task automatic test_branch();
        vreg_t r;
        addr_t tgt;
        addr_t exp [$];
        clear_memory();
        r   = 8'($urandom);
        tgt = 12'h260 + {4'h0, r};
        place(12'h200, {8'h60, r});
        place(12'h202, {8'h61, r});
        place(12'h204, {8'h62, r + 8'd1});
        place(12'h206, {8'h30, r});
        place(12'h20A, {8'h30, r + 8'd1});
        place(12'h20C, {8'h40, r + 8'd1});
        place(12'h210, {8'h40, r});
        place(12'h212, 16'h5010);
        place(12'h216, 16'h5020);
        place(12'h218, 16'h9020);
        place(12'h21C, 16'h9010);
        place(12'h21E, 16'h1240);
        place(12'h240, 16'hB260);
        place(tgt, {4'h1, tgt});
        exp = '{12'h200, 12'h202, 12'h204, 12'h206, 12'h20A, 12'h20C, 12'h210,
                12'h212, 12'h216, 12'h218, 12'h21C, 12'h21E, 12'h240, tgt, tgt};
        run_program(exp.size());
        if (read_log.size() < 2 * exp.size()) begin
            $display("branch test saw fewer instruction fetches than it executed");
            $display("Done: errors found");
            $fatal(1, "stopping at the first error");
        end
        for (int i = 0; i < exp.size(); i++) begin
            compare_addr($sformatf("branch fetch %0d", i), exp[i], read_log[2 * i]);
        end
    endtask

    task automatic test_subroutine();
        addr_t exp [$];
        clear_memory();
        place(12'h200, 16'h2210);
        place(12'h210, 16'h2220);
        place(12'h220, 16'h00EE);
        place(12'h212, 16'h00EE);
        place(12'h202, 16'h1202);
        exp = '{12'h200, 12'h210, 12'h220, 12'h212, 12'h202, 12'h202};
        run_program(exp.size());
        for (int i = 0; i < exp.size(); i++) begin
            compare_addr($sformatf("call fetch %0d", i), exp[i], read_log[2 * i]);
        end
    endtask

    task automatic test_bcd();
        vreg_t vals [5];
        bcd_t  exp;
        bcd_t  act;
        addr_t a;
        clear_memory();
        vals[0] = 8'd0;
        vals[1] = 8'd255;
        for (int k = 2; k < 5; k++) begin
            vals[k] = 8'($urandom);
        end
        for (int k = 0; k < 5; k++) begin
            emit({8'h60, vals[k]});
            emit({4'hA, 12'h400 + 12'(4 * k)});
            emit(16'hF033);
        end
        run_program(n_instr);
        for (int k = 0; k < 5; k++) begin
            a            = 12'h400 + 12'(4 * k);
            exp.hundreds = 4'(vals[k] / 100);
            exp.tens     = 4'((vals[k] / 10) % 10);
            exp.ones     = 4'(vals[k] % 10);
            act          = {mem[a][3:0], mem[a + 12'd1][3:0], mem[a + 12'd2][3:0]};
            compare_bcd($sformatf("bcd of %0d", vals[k]), exp, act);
            // Each digit byte has a clear upper nibble
            compare_byte($sformatf("bcd upper bits of %0d", vals[k]), 8'h00,
                         {4'h0, mem[a][7:4] | mem[a + 12'd1][7:4] | mem[a + 12'd2][7:4]});
        end
    endtask

    task automatic test_transfer();
        vreg_t pre [6];
        clear_memory();
        for (int k = 0; k < 6; k++) begin
            pre[k]               = 8'($urandom);
            mem[12'h500 + 12'(k)] = pre[k];
        end
        emit(16'hA500);
        // Load leaves I at 0x506, then I grows by 0x10
        emit(16'hF565);
        emit(16'h6710);
        emit(16'hF71E);
        emit(16'hF555);
        emit(16'hF055);
        run_program(n_instr);
        for (int k = 0; k < 6; k++) begin
            compare_byte($sformatf("store V%0d", k), pre[k], mem[12'h516 + 12'(k)]);
        end
        compare_byte("store after I update", pre[0], mem[12'h51C]);
        compare_byte("transfer write count", 8'd7, 8'(write_log.size()));
    endtask

    initial begin
        reset_i    = 1'b1;
        cpu_tick_i = 1'b0;
        cycle_cnt  = 0;
        void'($urandom(32'h3335));
        test_alu();
        test_branch();
        test_subroutine();
        test_bcd();
        test_transfer();
        $display("Done: no errors");
        $finish;
    end

endmodule

/* chip8_cpu.f */
design/chip8_isa_pkg.sv
design/chip8_mem_pkg.sv
design/chip8_regfile.sv
design/chip8_alu.sv
design/chip8_stack.sv
design/chip8_control.sv
design/chip8_cpu.sv
sim/chip8_properties.sv
sim/chip8_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the CHIP-8 testbench; exit status is the simulation result
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert \
    --top-module chip8_tb \
    -f chip8_cpu.f \
    -o chip8_sim
./obj_dir/chip8_sim
